// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mips_core_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/decode.sv
hdl/regfile.sv
hdl/alu.sv
hdl/pc_unit.sv
hdl/mips_core.sv
tb/mips_core_assertions.sv
tb/mips_core_tb.sv

// ==== hdl/alu.sv ====
`default_nettype none

module alu
    import core_pkg::*;
(
    input  logic [data_width-1:0] a,
    input  logic [data_width-1:0] b,
    input  alu_op_t               op,
    output logic [data_width-1:0] y
);

    logic [4:0] sa;
    logic       lt_signed;
    logic       lt_unsigned;

    assign sa          = a[4:0];  // shift amount
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add:      y = a + b;
            alu_sub:      y = a - b;
            alu_and:      y = a & b;
            alu_or:       y = a | b;
            alu_nor:      y = ~(a | b);
            alu_xor:      y = a ^ b;
            alu_sll:      y = b << sa;
            alu_sra:      y = $signed(b) >>> sa;
            alu_srl:      y = b >> sa;
            alu_slt:      y = {{(data_width-1){1'b0}}, lt_signed};
            alu_sltu:     y = {{(data_width-1){1'b0}}, lt_unsigned};
            alu_pass_imm: y = b;
            default:      y = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int          data_width = 32;
    localparam logic [31:0] reset_pc   = 32'h0000_0000;

    // alu control word encodings
    typedef enum logic [3:0] {
        alu_add      = 4'b0000,
        alu_sub      = 4'b0001,
        alu_and      = 4'b0010,
        alu_or       = 4'b0011,
        alu_nor      = 4'b0100,
        alu_xor      = 4'b0101,
        alu_sll      = 4'b0110,
        alu_sra      = 4'b0111,
        alu_srl      = 4'b1000,
        alu_slt      = 4'b1001,
        alu_sltu     = 4'b1010,
        alu_pass_imm = 4'b1111  // lui and jal link
    } alu_op_t;

    typedef enum logic [1:0] {
        jk_none     = 2'b00,
        jk_branch   = 2'b01,
        jk_jump     = 2'b10,
        jk_jump_reg = 2'b11
    } jump_kind_t;

    typedef enum logic [1:0] {
        dst_none   = 2'b00,
        dst_rd     = 2'b01,
        dst_rt     = 2'b10,
        dst_link31 = 2'b11
    } reg_dst_t;

    typedef enum logic [1:0] {
        imm_ext         = 2'b00,
        imm_upper       = 2'b01,
        imm_word_offset = 2'b10,
        imm_link_pc     = 2'b11
    } imm_kind_t;

endpackage

`default_nettype wire

// ==== hdl/decode.sv ====
`default_nettype none

module decode
    import isa_pkg::*, core_pkg::*;
(
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic [31:0] vs,
    input  logic [31:0] vt,
    output logic [4:0]  rs,
    output logic [4:0]  rt,
    output logic [4:0]  rd,
    output logic [4:0]  shamt,
    output logic [31:0] imm,
    output alu_op_t     alu_op,
    output logic        alu_use_imm,
    output logic        alu_use_shamt,
    output logic        reg_write,
    output logic        mem_to_reg,
    output logic        mem_write,
    output logic        branch_taken,
    output jump_kind_t  jump_kind
);

    opcode_t     op;
    funct_t      funct;
    logic [15:0] imm16;
    logic [31:0] ext_imm;
    logic        sign_ext;
    reg_dst_t    reg_dst;
    imm_kind_t   imm_kind;

    assign op    = opcode_t'(instr[op_msb:op_lsb]);
    assign funct = funct_t'(instr[funct_msb:funct_lsb]);
    assign rs    = instr[rs_msb:rs_lsb];
    assign rt    = instr[rt_msb:rt_lsb];
    assign shamt = instr[shamt_msb:shamt_lsb];
    assign imm16 = instr[imm_msb:imm_lsb];

    always_comb begin
        // anything unknown falls through as a no-op
        alu_op        = alu_add;
        alu_use_imm   = 1'b0;
        alu_use_shamt = 1'b0;
        reg_write     = 1'b0;
        mem_to_reg    = 1'b0;
        mem_write     = 1'b0;
        sign_ext      = 1'b0;
        reg_dst       = dst_none;
        imm_kind      = imm_ext;
        jump_kind     = jk_none;
        if (op == op_rtype) begin
            reg_write = 1'b1;
            reg_dst   = dst_rd;
            case (funct)
                fn_addu: alu_op = alu_add;
                fn_subu: alu_op = alu_sub;
                fn_and:  alu_op = alu_and;
                fn_or:   alu_op = alu_or;
                fn_nor:  alu_op = alu_nor;
                fn_xor:  alu_op = alu_xor;
                fn_slt:  alu_op = alu_slt;
                fn_sltu: alu_op = alu_sltu;
                fn_sll, fn_sra, fn_srl: begin
                    alu_use_shamt = 1'b1;
                    alu_op = (funct == fn_sll) ? alu_sll :
                             (funct == fn_sra) ? alu_sra : alu_srl;
                end
                fn_jr: begin
                    reg_write = 1'b0;
                    reg_dst   = dst_none;
                    jump_kind = jk_jump_reg;
                end
                default: begin
                    reg_write = 1'b0;
                    reg_dst   = dst_none;
                end
            endcase
        end else begin
            case (op)
                op_addiu, op_slti, op_sltiu, op_lw: begin
                    sign_ext    = 1'b1;
                    alu_use_imm = 1'b1;
                    reg_write   = 1'b1;
                    reg_dst     = dst_rt;
                    mem_to_reg  = (op == op_lw);
                    alu_op      = (op == op_slti)  ? alu_slt :
                                  (op == op_sltiu) ? alu_sltu : alu_add;
                end
                op_andi, op_ori, op_xori, op_lui: begin
                    alu_use_imm = 1'b1;  // zero-extended forms
                    reg_write   = 1'b1;
                    reg_dst     = dst_rt;
                    imm_kind    = (op == op_lui) ? imm_upper : imm_ext;
                    alu_op      = (op == op_andi) ? alu_and :
                                  (op == op_ori)  ? alu_or  :
                                  (op == op_xori) ? alu_xor : alu_pass_imm;
                end
                op_sw: begin
                    sign_ext    = 1'b1;
                    alu_use_imm = 1'b1;
                    mem_write   = 1'b1;
                end
                op_beq, op_bne: begin
                    sign_ext  = 1'b1;
                    imm_kind  = imm_word_offset;
                    jump_kind = jk_branch;
                end
                op_j: jump_kind = jk_jump;
                op_jal: begin
                    alu_use_imm = 1'b1;
                    alu_op      = alu_pass_imm;
                    reg_write   = 1'b1;
                    reg_dst     = dst_link31;
                    imm_kind    = imm_link_pc;
                    jump_kind   = jk_jump;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (reg_dst)
            dst_rd:     rd = instr[rd_msb:rd_lsb];
            dst_rt:     rd = rt;
            dst_link31: rd = 5'd31;
            default:    rd = 5'd0;
        endcase
    end

    assign ext_imm = sign_ext ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};

    always_comb begin
        case (imm_kind)
            imm_upper:       imm = {imm16, 16'h0000};
            imm_word_offset: imm = ext_imm << 2;
            imm_link_pc:     imm = pc + 32'd8;  // return past the delay slot
            default:         imm = ext_imm;
        endcase
    end

    assign branch_taken = ((op == op_beq) && (vs == vt)) ||
                          ((op == op_bne) && (vs != vt));

endmodule

`default_nettype wire

// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // instruction field positions
    localparam int op_msb     = 31;
    localparam int op_lsb     = 26;
    localparam int rs_msb     = 25;
    localparam int rs_lsb     = 21;
    localparam int rt_msb     = 20;
    localparam int rt_lsb     = 16;
    localparam int rd_msb     = 15;
    localparam int rd_lsb     = 11;
    localparam int shamt_msb  = 10;
    localparam int shamt_lsb  = 6;
    localparam int funct_msb  = 5;
    localparam int funct_lsb  = 0;
    localparam int imm_msb    = 15;
    localparam int imm_lsb    = 0;
    localparam int index_msb  = 25;
    localparam int index_lsb  = 0;

    typedef enum logic [5:0] {
        op_rtype = 6'b000000,
        op_j     = 6'b000010,
        op_jal   = 6'b000011,
        op_beq   = 6'b000100,
        op_bne   = 6'b000101,
        op_addiu = 6'b001001,
        op_slti  = 6'b001010,
        op_sltiu = 6'b001011,
        op_andi  = 6'b001100,
        op_ori   = 6'b001101,
        op_xori  = 6'b001110,
        op_lui   = 6'b001111,
        op_lw    = 6'b100011,
        op_sw    = 6'b101011
    } opcode_t;

    typedef enum logic [5:0] {
        fn_sll  = 6'b000000,
        fn_srl  = 6'b000010,
        fn_sra  = 6'b000011,
        fn_jr   = 6'b001000,
        fn_addu = 6'b100001,
        fn_subu = 6'b100011,
        fn_and  = 6'b100100,
        fn_or   = 6'b100101,
        fn_xor  = 6'b100110,
        fn_nor  = 6'b100111,
        fn_slt  = 6'b101010,
        fn_sltu = 6'b101011
    } funct_t;

endpackage

`default_nettype wire

// ==== hdl/mips_core.sv ====
`default_nettype none

module mips_core
    import isa_pkg::*, core_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] imem_data,
    input  logic [31:0] dmem_rdata,
    output logic [31:0] imem_addr,
    output logic [31:0] dmem_addr,
    output logic [31:0] dmem_wdata,
    output logic        dmem_we,
    output logic        commit_we,
    output logic [4:0]  commit_reg,
    output logic [31:0] commit_data
);

    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] vs;
    logic [31:0] vt;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    logic [31:0] imm;
    alu_op_t     alu_op;
    logic        alu_use_imm;
    logic        alu_use_shamt;
    logic        reg_write;
    logic        mem_to_reg;
    logic        mem_write;
    logic        branch_taken;
    jump_kind_t  jump_kind;
    logic        redirect;
    logic [31:0] target;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_y;
    logic [31:0] wb_data;
    logic        wb_en;

    pc_unit pc_i (
        .clk      (clk),
        .reset    (reset),
        .redirect (redirect),
        .target   (target),
        .pc       (pc)
    );

    decode decode_i (
        .instr         (imem_data),
        .pc            (pc),
        .vs            (vs),
        .vt            (vt),
        .rs            (rs),
        .rt            (rt),
        .rd            (rd),
        .shamt         (shamt),
        .imm           (imm),
        .alu_op        (alu_op),
        .alu_use_imm   (alu_use_imm),
        .alu_use_shamt (alu_use_shamt),
        .reg_write     (reg_write),
        .mem_to_reg    (mem_to_reg),
        .mem_write     (mem_write),
        .branch_taken  (branch_taken),
        .jump_kind     (jump_kind)
    );

    regfile regfile_i (
        .clk   (clk),
        .reset (reset),
        .we    (wb_en),
        .ra1   (rs),
        .ra2   (rt),
        .wa    (rd),
        .wd    (wb_data),
        .rd1   (vs),
        .rd2   (vt)
    );

    alu alu_i (
        .a  (alu_a),
        .b  (alu_b),
        .op (alu_op),
        .y  (alu_y)
    );

    assign imem_addr = pc;
    assign pc_plus4  = pc + 32'd4;

    // a not-taken branch leaves the pc alone
    assign redirect = branch_taken || (jump_kind == jk_jump) || (jump_kind == jk_jump_reg);

    always_comb begin
        case (jump_kind)
            jk_branch:   target = pc_plus4 + imm;
            jk_jump:     target = {pc_plus4[31:28], imem_data[index_msb:index_lsb], 2'b00};
            jk_jump_reg: target = vs;
            default:     target = pc_plus4;
        endcase
    end

    assign alu_a = alu_use_shamt ? {27'd0, shamt} : vs;
    assign alu_b = alu_use_imm ? imm : vt;

    assign dmem_addr  = alu_y;
    assign dmem_wdata = vt;
    assign dmem_we    = mem_write;

    assign wb_data = mem_to_reg ? dmem_rdata : alu_y;
    assign wb_en   = reg_write && (rd != 5'd0);  // writes to $zero are dropped

    assign commit_we   = wb_en;
    assign commit_reg  = rd;
    assign commit_data = wb_data;

endmodule

`default_nettype wire

// ==== hdl/pc_unit.sv ====
`default_nettype none

module pc_unit
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        redirect,
    input  logic [31:0] target,
    output logic [31:0] pc
);

    logic        pending;
    logic [31:0] pending_target;

    // the redirect waits one cycle so the delay slot at pc+4 still runs
    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= reset_pc;
            pending <= 1'b0;
        end else begin
            pc      <= pending ? pending_target : pc + 32'd4;
            pending <= redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect) begin
            pending_target <= target;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
`default_nettype none

module regfile
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  logic [4:0]            ra1,
    input  logic [4:0]            ra2,
    input  logic [4:0]            wa,
    input  logic [data_width-1:0] wd,
    output logic [data_width-1:0] rd1,
    output logic [data_width-1:0] rd2
);

    logic [data_width-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;
        end
    end

    // $zero reads as zero whatever the array holds
    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// ==== tb/mips_core_assertions.sv ====
`default_nettype none

module mips_core_assertions
    import core_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        dmem_we,
    input logic        commit_we,
    input logic [4:0]  commit_reg,
    input logic [31:0] imem_addr
);

    timeunit 1ns;
    timeprecision 1ps;

    store_without_commit: assert property (@(posedge clk) disable iff (reset)
        !(dmem_we && commit_we))
        else $error("dmem_we and commit_we are high in the same cycle");

    commit_not_zero: assert property (@(posedge clk) disable iff (reset)
        commit_we |-> (commit_reg != 5'd0))
        else $error("commit_we is high with commit_reg at zero");

    fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        imem_addr[1:0] == 2'b00)
        else $error("imem_addr is not word aligned");

    // first cycle out of reset fetches from the reset vector
    fetch_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (imem_addr == reset_pc))
        else $error("imem_addr is not at the reset pc after reset");

endmodule

bind mips_core mips_core_assertions assertions_i (
    .clk        (clk),
    .reset      (reset),
    .dmem_we    (dmem_we),
    .commit_we  (commit_we),
    .commit_reg (commit_reg),
    .imem_addr  (imem_addr)
);

`default_nettype wire

// ==== tb/mips_core_tb.sv ====
`default_nettype none

module mips_core_tb
    import isa_pkg::*, core_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        reset;
    logic [31:0] imem_data;
    logic [31:0] dmem_rdata;
    logic [31:0] imem_addr;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic        commit_we;
    logic [4:0]  commit_reg;
    logic [31:0] commit_data;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];

    string       row_name [$];
    logic [31:0] row_instr [$];
    logic [31:0] row_we [$];
    logic [31:0] row_reg [$];
    logic [31:0] row_data [$];
    logic [31:0] row_pc [$];
    logic [31:0] row_store [$];
    logic [31:0] row_maddr [$];
    logic [31:0] row_mdata [$];

    int errors      = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    mips_core dut_i (
        .clk         (clk),
        .reset       (reset),
        .imem_data   (imem_data),
        .dmem_rdata  (dmem_rdata),
        .imem_addr   (imem_addr),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_we     (dmem_we),
        .commit_we   (commit_we),
        .commit_reg  (commit_reg),
        .commit_data (commit_data)
    );

    assign imem_data  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < 64; k++) begin
                dmem[k] <= 32'hd000_0000 | 32'(k << 2);  // address in the low bits
            end
        end else if (dmem_we) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the program did not finish", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic add_row(input string name, input logic [31:0] instr, input logic we,
                           input logic [4:0] dst, input logic [31:0] data);
        row_name.push_back(name);
        row_instr.push_back(instr);
        row_we.push_back(32'(we));
        row_reg.push_back(32'(dst));
        row_data.push_back(data);
    endtask

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    // rows follow execution order so skipped words never appear
    task automatic load_program;
        add_row("addiu_neg",     32'h2401fffb, 1'b1, 5'd1,  32'hffff_fffb);
        add_row("ori_zext",      32'h34028001, 1'b1, 5'd2,  32'h0000_8001);
        add_row("lui",           32'h3c031234, 1'b1, 5'd3,  32'h1234_0000);
        add_row("addiu_r0",      32'h24000007, 1'b0, 5'd0,  32'h0000_0000);
        add_row("addiu_one",     32'h24040001, 1'b1, 5'd4,  32'h0000_0001);
        add_row("addu",          32'h00222821, 1'b1, 5'd5,  32'h0000_7ffc);
        add_row("subu",          32'h00443023, 1'b1, 5'd6,  32'h0000_8000);
        add_row("and",           32'h00a13824, 1'b1, 5'd7,  32'h0000_7ff8);
        add_row("or",            32'h00434025, 1'b1, 5'd8,  32'h1234_8001);
        add_row("nor",           32'h00434827, 1'b1, 5'd9,  32'hedcb_7ffe);
        add_row("xor",           32'h00615026, 1'b1, 5'd10, 32'hedcb_fffb);
        add_row("slt",           32'h0024582a, 1'b1, 5'd11, 32'h0000_0001);
        add_row("sltu",          32'h0024602b, 1'b1, 5'd12, 32'h0000_0000);
        add_row("sll",           32'h00046900, 1'b1, 5'd13, 32'h0000_0010);
        add_row("sra",           32'h00017043, 1'b1, 5'd14, 32'hffff_fffd);
        add_row("srl",           32'h00017842, 1'b1, 5'd15, 32'h7fff_fffd);
        add_row("addiu_base",    32'h24100040, 1'b1, 5'd16, 32'h0000_0040);
        add_row("sw",            32'hae030004, 1'b0, 5'd0,  32'h0000_0000);
        add_row("lw",            32'h8e110004, 1'b1, 5'd17, 32'h1234_0000);
        add_row("beq_taken",     32'h12230003, 1'b0, 5'd0,  32'h0000_0000);
        add_row("beq_slot",      32'h24120011, 1'b1, 5'd18, 32'h0000_0011);
        add_row("bne_not_taken", 32'h14840010, 1'b0, 5'd0,  32'h0000_0000);
        add_row("bne_slot",      32'h24130022, 1'b1, 5'd19, 32'h0000_0022);
        add_row("jal",           32'h0c000020, 1'b1, 5'd31, 32'h0000_006c);
        add_row("jal_slot",      32'h24140033, 1'b1, 5'd20, 32'h0000_0033);
        add_row("jal_target",    32'h24150044, 1'b1, 5'd21, 32'h0000_0044);
        add_row("jr",            32'h03e00008, 1'b0, 5'd0,  32'h0000_0000);
        add_row("jr_slot",       32'h24160055, 1'b1, 5'd22, 32'h0000_0055);
        add_row("j",             32'h08000024, 1'b0, 5'd0,  32'h0000_0000);
        add_row("j_slot",        32'h24170066, 1'b1, 5'd23, 32'h0000_0066);
        add_row("j_target",      32'h02f6c021, 1'b1, 5'd24, 32'h0000_00bb);
    endtask

    // walks the rows with a register model to get each pc and store
    task automatic build_expected_trace;
        logic [31:0] shadow [32];
        logic [31:0] pc;
        logic [31:0] pc4;
        logic [31:0] offset;
        logic [31:0] target;
        logic [31:0] pend_target;
        logic        pend;
        logic        redirect;
        opcode_t     op;
        funct_t      fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        for (int k = 0; k < 32; k++) begin
            shadow[k] = 32'd0;
        end
        for (int k = 0; k < 64; k++) begin
            imem[k] = 32'h2400_0000 | 32'(k << 2);  // addiu to $zero that never commits
        end
        pc          = reset_pc;
        pend        = 1'b0;
        pend_target = 32'd0;
        for (int i = 0; i < row_name.size(); i++) begin
            op       = opcode_t'(row_instr[i][op_msb:op_lsb]);
            fn       = funct_t'(row_instr[i][funct_msb:funct_lsb]);
            rs       = row_instr[i][rs_msb:rs_lsb];
            rt       = row_instr[i][rt_msb:rt_lsb];
            offset   = {{16{row_instr[i][imm_msb]}}, row_instr[i][imm_msb:imm_lsb]};
            pc4      = pc + 32'd4;
            redirect = 1'b0;
            target   = pc4;
            if (op == op_beq) begin
                redirect = (shadow[rs] == shadow[rt]);
                target   = pc4 + (offset << 2);
            end else if (op == op_bne) begin
                redirect = (shadow[rs] != shadow[rt]);
                target   = pc4 + (offset << 2);
            end else if ((op == op_j) || (op == op_jal)) begin
                redirect = 1'b1;
                target   = {pc4[31:28], row_instr[i][index_msb:index_lsb], 2'b00};
            end else if ((op == op_rtype) && (fn == fn_jr)) begin
                redirect = 1'b1;
                target   = shadow[rs];
            end
            imem[pc[7:2]] = row_instr[i];
            row_pc.push_back(pc);
            row_store.push_back(32'(op == op_sw));
            row_maddr.push_back(shadow[rs] + offset);
            row_mdata.push_back(shadow[rt]);
            if (row_we[i][0] && (row_reg[i] != 32'd0)) begin
                shadow[row_reg[i][4:0]] = row_data[i];
            end
            pc          = pend ? pend_target : pc4;  // slot first and then the target
            pend        = redirect;
            pend_target = target;
        end
    endtask

    task automatic check_row(input int i);
        compare_value({row_name[i], " pc"}, row_pc[i], imem_addr);
        compare_value({row_name[i], " commit_we"}, row_we[i], 32'(commit_we));
        if (row_we[i][0]) begin
            compare_value({row_name[i], " commit_reg"}, row_reg[i], 32'(commit_reg));
            compare_value({row_name[i], " commit_data"}, row_data[i], commit_data);
        end
        compare_value({row_name[i], " dmem_we"}, row_store[i], 32'(dmem_we));
        if (row_store[i][0]) begin
            compare_value({row_name[i], " dmem_addr"}, row_maddr[i], dmem_addr);
            compare_value({row_name[i], " dmem_wdata"}, row_mdata[i], dmem_wdata);
        end
    endtask

    initial begin
        reset = 1'b1;
        load_program;
        build_expected_trace;
        cycle_limit = 2 * row_name.size() + 20;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < row_name.size(); i++) begin
            check_row(i);  // outputs settled since the last rising edge
            @(negedge clk);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
